// File: rtl/rv_pkg.sv
//////////////////////////////////////////////////
// Shared types for the execute subsystem
// Operation, CSR and privilege enums, width types,
// CSR addresses and data RAM depth
//////////////////////////////////////////////////

package rv_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int RAM_WORDS = 64;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [XLEN/8-1:0] byte_en_t;
    typedef logic [11:0]       csr_addr_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;

    //////////////////////////////////////////////////
    // Implemented CSRs
    //////////////////////////////////////////////////

    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    // User level, read only
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;

    //////////////////////////////////////////////////
    // Decoded operations
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI
    } op_e;

    typedef enum logic [1:0] {
        NONE,
        WRITE,
        SET,
        CLEAR
    } csr_op_e;

    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_e;

endpackage

// File: rtl/data_ram.sv
//////////////////////////////////////////////////
// Byte-enabled data RAM, registered read port
//////////////////////////////////////////////////

module data_ram (
    input  logic               clk,
    input  rv_pkg::byte_en_t   we_i,
    input  rv_pkg::ram_addr_t  waddr_i,
    input  rv_pkg::ram_addr_t  raddr_i,
    input  rv_pkg::word_t      wdata_i,
    input  logic               re_i,
    output rv_pkg::word_t      rdata_o
);
    import rv_pkg::*;

    word_t mem [RAM_WORDS];

    // One lane per write enable bit
    always_ff @(posedge clk) begin
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (we_i[b]) begin
                mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    // Old data on a same-edge write
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// File: rtl/csr_file.sv
//////////////////////////////////////////////////
// Machine-mode CSRs with write/set/clear and a
// free-running cycle counter
//////////////////////////////////////////////////

module csr_file (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               valid_i,
    input  logic               stall_i,
    input  logic               csr_read_i,
    input  logic               csr_write_i,
    input  rv_pkg::csr_op_e    csr_op_i,
    input  rv_pkg::csr_addr_t  csr_addr_i,
    input  rv_pkg::word_t      csr_wdata_i,
    output rv_pkg::word_t      csr_rdata_o
);
    import rv_pkg::*;

    word_t mscratch;
    word_t mtvec;
    word_t mepc;
    word_t cycle;
    word_t cur_value;
    word_t next_value;
    logic  wr_en;

    // Addressed register, zero when not implemented
    always_comb begin
        unique case (csr_addr_i)
            CSR_MSCRATCH: cur_value = mscratch;
            CSR_MTVEC:    cur_value = mtvec;
            CSR_MEPC:     cur_value = mepc;
            CSR_CYCLE:    cur_value = cycle;
            default:      cur_value = '0;
        endcase
    end

    assign csr_rdata_o = csr_read_i ? cur_value : '0;

    always_comb begin
        unique case (csr_op_i)
            WRITE:   next_value = csr_wdata_i;
            SET:     next_value = cur_value | csr_wdata_i;
            CLEAR:   next_value = cur_value & ~csr_wdata_i;
            default: next_value = cur_value;
        endcase
    end

    // Only on the accepting edge
    assign wr_en = csr_write_i & valid_i & ~stall_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            cycle    <= '0;
        end else begin
            cycle <= cycle + 32'd1;
            if (wr_en) begin
                unique case (csr_addr_i)
                    CSR_MSCRATCH: mscratch <= next_value;
                    CSR_MTVEC:    mtvec    <= next_value;
                    CSR_MEPC:     mepc     <= next_value;
                    default: ;
                endcase
            end
        end
    end

    // Execute must always name an operation with a write
    assert property (@(posedge clk) disable iff (rst_i)
        csr_write_i |-> (csr_op_i != NONE));

endmodule

// File: rtl/execute.sv
//////////////////////////////////////////////////
// Execute stage with adders, logic, shifts, branch
// compare, load/store, CSR access and output regs
//////////////////////////////////////////////////

module execute (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               valid_i,
    input  logic               stall_i,
    input  rv_pkg::op_e        op_i,
    input  rv_pkg::word_t      pc_i,
    input  rv_pkg::word_t      instr_i,
    input  rv_pkg::word_t      opa_i,
    input  rv_pkg::word_t      opb_i,
    input  rv_pkg::word_t      opc_i,
    input  rv_pkg::priv_e      priv_i,
    input  rv_pkg::word_t      csr_rdata_i,

    output logic               valid_o,
    output rv_pkg::word_t      result0_o,
    output rv_pkg::word_t      result1_o,
    output logic               jump_o,
    output logic               reg_write_o,
    output logic               illegal_o,
    output rv_pkg::byte_en_t   mem_we_o,
    output rv_pkg::ram_addr_t  mem_waddr_o,
    output rv_pkg::ram_addr_t  mem_raddr_o,
    output logic               mem_read_o,
    output logic               csr_read_o,
    output logic               csr_write_o,
    output rv_pkg::csr_op_e    csr_op_o,
    output rv_pkg::csr_addr_t  csr_addr_o,
    output rv_pkg::word_t      csr_wdata_o
);
    import rv_pkg::*;

    word_t    sum_result;
    word_t    sum2_opa;
    word_t    sum2_opb;
    word_t    sum2_result;
    word_t    store_data;
    word_t    result0;
    word_t    result1;
    byte_en_t store_be;
    logic     eq;
    logic     lt;
    logic     ltu;
    logic     jump;
    logic     reg_write;
    logic     is_load;
    logic     csr_re;
    logic     csr_we;
    logic     csr_illegal;
    logic [4:0] rd;
    logic [4:0] rs1;

    //////////////////////////////////////////////////
    // Adders and compare
    //////////////////////////////////////////////////

    // Second adder forms pc+4 for links, the difference for SUB and the branch target
    always_comb begin
        sum2_opa = (op_i == SUB) ? opa_i : pc_i;
        unique case (op_i)
            JAL, JALR: sum2_opb = 32'd4;
            SUB:       sum2_opb = -opb_i;
            default:   sum2_opb = opc_i;
        endcase
    end

    assign sum_result  = opa_i + opb_i;
    assign sum2_result = sum2_opa + sum2_opb;

    assign eq  = (opa_i == opb_i);
    assign lt  = ($signed(opa_i) < $signed(opb_i));
    assign ltu = (opa_i < opb_i);

    always_comb begin
        unique case (op_i)
            BEQ:       jump = eq;
            BNE:       jump = ~eq;
            BLT:       jump = lt;
            BLTU:      jump = ltu;
            BGE:       jump = ~lt;
            BGEU:      jump = ~ltu;
            JAL, JALR: jump = 1'b1;
            default:   jump = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Load/store
    //////////////////////////////////////////////////

    assign is_load     = (op_i inside {LB, LBU, LH, LHU, LW});
    assign mem_read_o  = is_load & valid_i & ~stall_i;
    assign mem_raddr_o = sum_result[RAM_AW+1:2];

    // Store data replicated over the lanes
    always_comb begin
        unique case (op_i)
            SB:      store_data = {4{opc_i[7:0]}};
            SH:      store_data = {2{opc_i[15:0]}};
            SW:      store_data = opc_i;
            default: store_data = '0;
        endcase
    end

    always_comb begin
        unique case (op_i)
            SB:      store_be = byte_en_t'(4'b0001 << sum_result[1:0]);
            SH:      store_be = sum_result[1] ? 4'b1100 : 4'b0011;
            SW:      store_be = 4'b1111;
            default: store_be = 4'b0000;
        endcase
    end

    //////////////////////////////////////////////////
    // CSR access
    //////////////////////////////////////////////////

    assign rd         = instr_i[11:7];
    assign rs1        = instr_i[19:15];
    assign csr_addr_o = instr_i[31:20];

    // Reads skipped for rd=x0 on swaps and writes skipped for rs1=0 on set/clear
    always_comb begin
        unique case (op_i)
            CSRRW, CSRRWI: begin
                csr_re = (rd != '0);
                csr_we = 1'b1;
            end
            CSRRS, CSRRC, CSRRSI, CSRRCI: begin
                csr_re = 1'b1;
                csr_we = (rs1 != '0);
            end
            default: begin
                csr_re = 1'b0;
                csr_we = 1'b0;
            end
        endcase
    end

    always_comb begin
        unique case (op_i)
            CSRRW, CSRRWI: csr_op_o = WRITE;
            CSRRS, CSRRSI: csr_op_o = SET;
            CSRRC, CSRRCI: csr_op_o = CLEAR;
            default:       csr_op_o = NONE;
        endcase
    end

    assign csr_wdata_o = (op_i inside {CSRRW, CSRRS, CSRRC}) ? opa_i : {27'b0, rs1};

    // Read-only space written or privilege field above current level
    assign csr_illegal = ((csr_addr_o[11:10] == 2'b11) && csr_we)
                       || ((csr_addr_o[9:8] > priv_i) && (csr_re || csr_we));

    assign csr_read_o  = csr_re & ~csr_illegal;
    assign csr_write_o = csr_we & ~csr_illegal & valid_i;

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: result0 = csr_rdata_i;
            JAL, JALR, SUB:         result0 = sum2_result;
            SLT:                    result0 = {31'b0, lt};
            SLTU:                   result0 = {31'b0, ltu};
            XOR:                    result0 = opa_i ^ opb_i;
            OR:                     result0 = opa_i | opb_i;
            AND:                    result0 = opa_i & opb_i;
            SLL:                    result0 = opa_i << opb_i[4:0];
            SRL:                    result0 = opa_i >> opb_i[4:0];
            SRA:                    result0 = $signed(opa_i) >>> opb_i[4:0];
            LUI:                    result0 = opb_i;
            default:                result0 = sum_result;
        endcase
    end

    always_comb begin
        unique case (op_i)
            SB, SH, SW: result1 = store_data;
            JALR:       result1 = {sum_result[31:1], 1'b0};
            JAL:        result1 = sum_result;
            default:    result1 = sum2_result;
        endcase
    end

    assign reg_write = !(op_i inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU});

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o     <= 1'b0;
            jump_o      <= 1'b0;
            reg_write_o <= 1'b0;
            illegal_o   <= 1'b0;
            mem_we_o    <= '0;
        end else if (!stall_i) begin
            valid_o     <= valid_i;
            jump_o      <= jump;
            reg_write_o <= reg_write;
            illegal_o   <= csr_illegal;
            mem_we_o    <= valid_i ? store_be : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result0_o   <= result0;
            result1_o   <= result1;
            mem_waddr_o <= sum_result[RAM_AW+1:2];
        end
    end

    // No RAM write can be pending behind an empty output slot
    assert property (@(posedge clk) disable iff (rst_i)
        !valid_o |-> (mem_we_o == '0));

    // No CSR write reaches read-only space or a level above the current one
    assert property (@(posedge clk) disable iff (rst_i)
        csr_write_o |-> (csr_addr_o[11:10] != 2'b11) && (csr_addr_o[9:8] <= priv_i));

endmodule

// File: rtl/exec_top.sv
//////////////////////////////////////////////////
// Execute subsystem top: stage, CSR file, data RAM
//////////////////////////////////////////////////

module exec_top (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           valid_i,
    input  logic           stall_i,
    input  rv_pkg::op_e    op_i,
    input  rv_pkg::word_t  pc_i,
    input  rv_pkg::word_t  instr_i,
    input  rv_pkg::word_t  opa_i,
    input  rv_pkg::word_t  opb_i,
    input  rv_pkg::word_t  opc_i,
    input  rv_pkg::priv_e  priv_i,

    output logic           valid_o,
    output rv_pkg::word_t  result0_o,
    output rv_pkg::word_t  result1_o,
    output logic           jump_o,
    output logic           reg_write_o,
    output logic           illegal_o,
    output rv_pkg::word_t  load_data_o
);
    import rv_pkg::*;

    word_t     csr_rdata;
    word_t     csr_wdata;
    csr_addr_t csr_addr;
    csr_op_e   csr_op;
    logic      csr_read;
    logic      csr_write;
    byte_en_t  mem_we;
    ram_addr_t mem_waddr;
    ram_addr_t mem_raddr;
    logic      mem_read;

    execute execute_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .stall_i     (stall_i),
        .op_i        (op_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .opa_i       (opa_i),
        .opb_i       (opb_i),
        .opc_i       (opc_i),
        .priv_i      (priv_i),
        .csr_rdata_i (csr_rdata),
        .valid_o     (valid_o),
        .result0_o   (result0_o),
        .result1_o   (result1_o),
        .jump_o      (jump_o),
        .reg_write_o (reg_write_o),
        .illegal_o   (illegal_o),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_raddr_o (mem_raddr),
        .mem_read_o  (mem_read),
        .csr_read_o  (csr_read),
        .csr_write_o (csr_write),
        .csr_op_o    (csr_op),
        .csr_addr_o  (csr_addr),
        .csr_wdata_o (csr_wdata)
    );

    csr_file csr_file_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .stall_i     (stall_i),
        .csr_read_i  (csr_read),
        .csr_write_i (csr_write),
        .csr_op_i    (csr_op),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata)
    );

    // Store data comes from the registered result1
    data_ram data_ram_i (
        .clk     (clk),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .raddr_i (mem_raddr),
        .wdata_i (result1_o),
        .re_i    (mem_read),
        .rdata_o (load_data_o)
    );

endmodule

// File: bench/exec_tb.sv
//////////////////////////////////////////////////
// Testbench for exec_top with case table reader,
// falling-edge driver, output checks and summary
//////////////////////////////////////////////////

module exec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    localparam string CASE_FILE = "bench/exec_cases.txt";

    logic  clk;
    logic  rst_i;
    logic  valid_i;
    logic  stall_i;
    op_e   op_i;
    word_t pc_i;
    word_t instr_i;
    word_t opa_i;
    word_t opb_i;
    word_t opc_i;
    priv_e priv_i;

    logic  valid_o;
    word_t result0_o;
    word_t result1_o;
    logic  jump_o;
    logic  reg_write_o;
    logic  illegal_o;
    word_t load_data_o;

    // Current case and its expected outputs
    string      case_name;
    word_t      exp_r0;
    word_t      exp_r1;
    word_t      exp_ld;
    logic       exp_jump;
    logic       exp_rw;
    logic       exp_ill;
    // Bit 0 result0, 1 result1, 2 jump, 3 reg_write, 4 illegal, 5 load_data
    logic [7:0] check_mask;

    string case_lines[$];
    int    cycles = 0;
    int    cycle_limit = 20;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    mismatches = 0;

    exec_top exec_top_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .stall_i     (stall_i),
        .op_i        (op_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .opa_i       (opa_i),
        .opb_i       (opb_i),
        .opc_i       (opc_i),
        .priv_i      (priv_i),
        .valid_o     (valid_o),
        .result0_o   (result0_o),
        .result1_o   (result1_o),
        .jump_o      (jump_o),
        .reg_write_o (reg_write_o),
        .illegal_o   (illegal_o),
        .load_data_o (load_data_o)
    );

    always #4 clk = ~clk;

    // Run limit is armed once the case table is read
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // Mnemonic in the case file to operation code
    function automatic bit find_op(input string name, output op_e op);
        op_e cand;
        cand = cand.first();
        op = ADD;
        for (int i = 0; i < cand.num(); i++) begin
            if (cand.name() == name) begin
                op = cand;
                return 1'b1;
            end
            cand = cand.next();
        end
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string field, input word_t expected,
                                   input word_t actual);
        $display("FAIL %s %s expected %h actual %h", case_name, field, expected, actual);
        mismatches++;
    endtask

    task automatic finish_test();
        if (mismatches == 0) begin
            $display("ok   %s", case_name);
        end else begin
            tests_failed++;
        end
    endtask

    task automatic check_outputs();
        if (valid_o !== 1'b1) begin
            report_mismatch("valid_o", 32'd1, {31'b0, valid_o});
        end
        if (check_mask[0] && result0_o !== exp_r0) begin
            report_mismatch("result0", exp_r0, result0_o);
        end
        if (check_mask[1] && result1_o !== exp_r1) begin
            report_mismatch("result1", exp_r1, result1_o);
        end
        if (check_mask[2] && jump_o !== exp_jump) begin
            report_mismatch("jump", {31'b0, exp_jump}, {31'b0, jump_o});
        end
        if (check_mask[3] && reg_write_o !== exp_rw) begin
            report_mismatch("reg_write", {31'b0, exp_rw}, {31'b0, reg_write_o});
        end
        if (check_mask[4] && illegal_o !== exp_ill) begin
            report_mismatch("illegal", {31'b0, exp_ill}, {31'b0, illegal_o});
        end
        if (check_mask[5] && load_data_o !== exp_ld) begin
            report_mismatch("load_data", exp_ld, load_data_o);
        end
    endtask

    // Called on a falling edge and returns on the falling edge of the last check
    task automatic run_case(input string line);
        string op_name;
        op_e   op;
        int    priv;
        int    stall;
        int    fields;
        fields = $sscanf(line, "%s %s %h %h %h %h %h %d %d %h %h %d %d %d %h %h",
                         case_name, op_name, pc_i, instr_i, opa_i, opb_i, opc_i,
                         priv, stall, exp_r0, exp_r1, exp_jump, exp_rw, exp_ill,
                         exp_ld, check_mask);
        tests_run++;
        mismatches = 0;
        if (fields != 16 || !find_op(op_name, op)) begin
            $display("case line %0d could not be parsed", tests_run - 1);
            valid_i = 1'b0;
            tests_failed++;
        end else begin
            valid_i = 1'b1;
            stall_i = (stall != 0);
            op_i    = op;
            priv_i  = priv_e'(priv[1:0]);
            @(negedge clk);
            check_outputs();
            // A stalled instruction keeps the old outputs for as long as it waits
            if (stall != 0) begin
                @(negedge clk);
                check_outputs();
                stall_i = 1'b0;
            end
            finish_test();
        end
    endtask

    initial begin
        int    fd;
        int    status;
        string line;
        clk     = 1'b0;
        rst_i   = 1'b1;
        valid_i = 1'b0;
        stall_i = 1'b0;
        op_i    = ADD;
        pc_i    = '0;
        instr_i = '0;
        opa_i   = '0;
        opb_i   = '0;
        opc_i   = '0;
        priv_i  = MACHINE;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            tests_failed++;
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                // Blank lines and the column header
                if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    case_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = 4 * case_lines.size() + 20;

        repeat (2) @(negedge clk);
        rst_i = 1'b0;

        //////////////////////////////////////////////////
        // Reset state and the case table
        //////////////////////////////////////////////////

        // First cycle after the last reset edge
        case_name  = "reset";
        mismatches = 0;
        tests_run++;
        if (valid_o !== 1'b0) begin
            report_mismatch("valid_o", 32'd0, {31'b0, valid_o});
        end
        if (jump_o !== 1'b0) begin
            report_mismatch("jump", 32'd0, {31'b0, jump_o});
        end
        if (reg_write_o !== 1'b0) begin
            report_mismatch("reg_write", 32'd0, {31'b0, reg_write_o});
        end
        if (illegal_o !== 1'b0) begin
            report_mismatch("illegal", 32'd0, {31'b0, illegal_o});
        end
        finish_test();

        foreach (case_lines[i]) begin
            run_case(case_lines[i]);
        end
        valid_i = 1'b0;
        stall_i = 1'b0;

        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0 && case_lines.size() > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/exec_cases.txt
# name op pc instr opa opb opc priv stall | result0 result1 jump reg_write illegal load_data mask
# mask bits (hex): 0 result0, 1 result1, 2 jump, 3 reg_write, 4 illegal, 5 load_data
add       ADD    00000100 00000000 00001234 0000ffff 00000000 3 0 00011233 00000000 0 1 0 00000000 1d
sub       SUB    00000100 00000000 00000005 00000007 00000000 3 0 fffffffe 00000000 0 1 0 00000000 1d
xor       XOR    00000100 00000000 f0f0f0f0 ff00ff00 00000000 3 0 0ff00ff0 00000000 0 1 0 00000000 1d
or        OR     00000100 00000000 f0f0f0f0 ff00ff00 00000000 3 0 fff0fff0 00000000 0 1 0 00000000 1d
and       AND    00000100 00000000 f0f0f0f0 ff00ff00 00000000 3 0 f000f000 00000000 0 1 0 00000000 1d
sll       SLL    00000100 00000000 80000001 00000024 00000000 3 0 00000010 00000000 0 1 0 00000000 1d
srl       SRL    00000100 00000000 80000010 00000024 00000000 3 0 08000001 00000000 0 1 0 00000000 1d
sra       SRA    00000100 00000000 80000010 00000024 00000000 3 0 f8000001 00000000 0 1 0 00000000 1d
slt       SLT    00000100 00000000 80000000 7fffffff 00000000 3 0 00000001 00000000 0 1 0 00000000 1d
sltu      SLTU   00000100 00000000 80000000 7fffffff 00000000 3 0 00000000 00000000 0 1 0 00000000 1d
lui       LUI    00000100 00000000 00000000 12345000 00000000 3 0 12345000 00000000 0 1 0 00000000 1d
beq       BEQ    00000100 00000000 00000005 00000005 00000020 3 0 00000000 00000120 1 0 0 00000000 1e
bne       BNE    00000100 00000000 00000005 00000005 00000020 3 0 00000000 00000120 0 0 0 00000000 1e
blt       BLT    00000100 00000000 ffffffff 00000001 00000020 3 0 00000000 00000120 1 0 0 00000000 1e
bltu      BLTU   00000100 00000000 ffffffff 00000001 00000020 3 0 00000000 00000120 0 0 0 00000000 1e
bge       BGE    00000100 00000000 ffffffff 00000001 00000020 3 0 00000000 00000120 0 0 0 00000000 1e
bgeu      BGEU   00000100 00000000 ffffffff 00000001 00000020 3 0 00000000 00000120 1 0 0 00000000 1e
jal       JAL    00000200 00000000 00000200 00000040 00000000 3 0 00000204 00000240 1 1 0 00000000 1f
jalr      JALR   00000200 00000000 00001001 00000004 00000000 3 0 00000204 00001004 1 1 0 00000000 1f
sw        SW     00000100 00000000 00000040 00000000 11223344 3 0 00000000 11223344 0 0 0 00000000 1e
sb        SB     00000100 00000000 00000040 00000001 000000aa 3 0 00000000 aaaaaaaa 0 0 0 00000000 1e
sh        SH     00000100 00000000 00000040 00000002 0000bbcc 3 0 00000000 bbccbbcc 0 0 0 00000000 1e
sw_next   SW     00000100 00000000 00000044 00000000 55667788 3 0 00000000 55667788 0 0 0 00000000 1e
lw_merge  LW     00000100 00000000 00000040 00000000 00000000 3 0 00000000 00000000 0 1 0 bbccaa44 3c
lw_next   LW     00000100 00000000 00000040 00000004 00000000 3 0 00000000 00000000 0 1 0 55667788 3c
csr_rw    CSRRW  00000100 340090f3 a5a50000 00000000 00000000 3 0 00000000 00000000 0 1 0 00000000 1d
csr_set   CSRRS  00000100 3400a0f3 0000ffff 00000000 00000000 3 0 a5a50000 00000000 0 1 0 00000000 1d
csr_clr   CSRRC  00000100 3400b0f3 a5000000 00000000 00000000 3 0 a5a5ffff 00000000 0 1 0 00000000 1d
csr_read  CSRRS  00000100 340020f3 00000000 00000000 00000000 3 0 00a5ffff 00000000 0 1 0 00000000 1d
csr_stall CSRRW  00000100 340090f3 12345678 00000000 00000000 3 1 00a5ffff 00000000 0 1 0 00000000 1d
csr_hold  CSRRS  00000100 340020f3 00000000 00000000 00000000 3 0 00a5ffff 00000000 0 1 0 00000000 1d
cyc_write CSRRW  00000100 c00090f3 00000001 00000000 00000000 3 0 00000000 00000000 0 1 1 00000000 18
csr_user  CSRRW  00000100 340090f3 ffffffff 00000000 00000000 0 0 00000000 00000000 0 1 1 00000000 18
csr_keep  CSRRS  00000100 340020f3 00000000 00000000 00000000 3 0 00a5ffff 00000000 0 1 0 00000000 19
cyc_read  CSRRS  00000100 c00020f3 00000000 00000000 00000000 0 0 00000000 00000000 0 1 0 00000000 18

// File: project.f
rtl/rv_pkg.sv
rtl/data_ram.sv
rtl/csr_file.sv
rtl/execute.sv
rtl/exec_top.sv
bench/exec_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the execute subsystem testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
    verilator --binary --assert --top-module exec_tb -f project.f &&
    ./obj_dir/Vexec_tb | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
    echo "PASS" ||
    { echo "FAIL"; exit 1; }
